// File: design/spm_defines.svh
// ========================================
// spm shared widths
// address, data and tag widths and the
// scratchpad depth for every block
// ========================================

`ifndef SPM_DEFINES_SVH
`define SPM_DEFINES_SVH

`define SPM_ADDR_W 8    // word address bits
`define SPM_DEPTH  256  // words in the scratchpad, full address range
`define SPM_DATA_W 32   // bits per word
`define SPM_TAG_W  8    // client read tag returned with the data

`endif

// File: design/spm_pkg.sv
// ========================================
// spm package
// command union, opcode and the structs
// passed between pipeline stages
// ========================================

`include "spm_defines.svh"

package spm_pkg;

  // one opcode bit at the top of every command word
  typedef enum logic {
    SPM_OP_READ  = 1'b0,
    SPM_OP_WRITE = 1'b1
  } spm_op_e;

  // write view of the command word
  typedef struct packed {
    spm_op_e                op;    // SPM_OP_WRITE
    logic [`SPM_ADDR_W-1:0] addr;  // target word
    logic [`SPM_DATA_W-1:0] data;  // full word, no byte mask
  } spm_cmd_wr_s;

  // read view of the command word
  typedef struct packed {
    spm_op_e                           op;    // SPM_OP_READ
    logic [`SPM_ADDR_W-1:0]            addr;  // source word
    logic [`SPM_TAG_W-1:0]             tag;   // echoed back in the response
    logic [`SPM_DATA_W-`SPM_TAG_W-1:0] rsvd;  // don't care
  } spm_cmd_rd_s;

  // 41-bit command word, op and addr sit at the same bits in both views
  typedef union packed {
    spm_cmd_wr_s wr;
    spm_cmd_rd_s rd;
  } spm_cmd_u;

  // request stage to memory and response stage
  typedef struct packed {
    logic                   v;     // access this cycle
    logic                   w;     // 1 write / 0 read, only meaningful with v
    logic [`SPM_ADDR_W-1:0] addr;
    logic [`SPM_DATA_W-1:0] data;  // write data
    logic [`SPM_TAG_W-1:0]  tag;   // read tag
  } spm_mem_req_s;

  // read response to the client
  typedef struct packed {
    logic [`SPM_TAG_W-1:0]  tag;
    logic [`SPM_DATA_W-1:0] data;
  } spm_resp_s;

endpackage

// File: design/spm_req_stage.sv
// ========================================
// spm request stage
// decodes the client command word and
// registers the memory access controls
// ========================================

`timescale 1ns/1ps

module spm_req_stage (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  cmd_v_i,    // one command per cycle, no handshake
  input  spm_pkg::spm_cmd_u     cmd_i,
  output spm_pkg::spm_mem_req_s mem_req_o
);

  logic                  is_wr;   // decoded opcode
  spm_pkg::spm_mem_req_s req_q;   // registered request

  // opcode is common to both views, the write view is as good as any
  assign is_wr = (cmd_i.wr.op == spm_pkg::SPM_OP_WRITE);

  // control bits
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      req_q.v <= 1'b0;
      req_q.w <= 1'b0;
    end
    else
    begin
      req_q.v <= cmd_v_i;
      req_q.w <= cmd_v_i & is_wr;  // never a write without a strobe
    end
  end

  // payload only moves on an accepted command
  always_ff @(posedge clk_i)
  begin
    if (cmd_v_i)
    begin
      req_q.addr <= cmd_i.wr.addr;   // same bits in the read view
      if (is_wr)
      begin
        req_q.data <= cmd_i.wr.data;   // whole low word is data
      end
      else
      begin
        req_q.tag <= cmd_i.rd.tag;     // rsvd bits dropped here
      end
    end
  end

  // straight out of the register, one cycle after the command
  assign mem_req_o = req_q;

endmodule

// File: design/spm_mem_1rw_sync.sv
// ========================================
// spm single-port ram
// one read or one write per cycle, read
// data held in an output register
// ========================================

`timescale 1ns/1ps

`include "spm_defines.svh"

module spm_mem_1rw_sync #(
  parameter  int data_w_p  = `SPM_DATA_W,   // bits per word
  parameter  int depth_p   = `SPM_DEPTH,    // number of words
  localparam int addr_w_lp = $clog2(depth_p)
) (
  input  logic                 clk_i,
  input  logic                 v_i,      // access enable
  input  logic                 w_i,      // 1 write, 0 read
  input  logic [addr_w_lp-1:0] addr_i,
  input  logic [data_w_p-1:0]  data_i,   // write data
  output logic [data_w_p-1:0]  data_o    // read data, valid the cycle after the read
);

  // storage array, contents undefined until written
  logic [data_w_p-1:0] mem_r [depth_p];

  // single port: the access is either a write or a read, never both
  always_ff @(posedge clk_i)
  begin
    if (v_i)
    begin
      if (w_i)
      begin
        mem_r[addr_i] <= data_i;     // write, output register untouched
      end
      else
      begin
        data_o <= mem_r[addr_i];     // registered read
      end
    end
    // idle cycles keep the last read word on data_o
  end

endmodule

// File: design/spm_resp_stage.sv
// ========================================
// spm response stage
// lines each read tag up with the ram
// data and registers the response
// ========================================

`timescale 1ns/1ps

`include "spm_defines.svh"

module spm_resp_stage (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   rd_v_i,     // read issued to the ram this cycle
  input  logic [`SPM_TAG_W-1:0]  tag_i,      // tag of that read
  input  logic [`SPM_DATA_W-1:0] rd_data_i,  // ram output register
  output logic                   resp_v_o,   // single-cycle response strobe
  output spm_pkg::spm_resp_s     resp_o
);

  logic                  rd_v_q;  // read pulse, aligned with rd_data_i
  logic [`SPM_TAG_W-1:0] tag_q;   // tag, aligned with rd_data_i

  // strobes
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      rd_v_q   <= 1'b0;
      resp_v_o <= 1'b0;
    end
    else
    begin
      rd_v_q   <= rd_v_i;   // ram needs one cycle for the data
      resp_v_o <= rd_v_q;   // then one more for the response register
    end
  end

  // tag delay matches the ram read register
  always_ff @(posedge clk_i)
  begin
    if (rd_v_i)
    begin
      tag_q <= tag_i;
    end
  end

  // response payload, held between reads
  always_ff @(posedge clk_i)
  begin
    if (rd_v_q)
    begin
      resp_o.tag  <= tag_q;
      resp_o.data <= rd_data_i;   // ram output valid this cycle
    end
  end

endmodule

// File: design/spm_top.sv
// ========================================
// spm top
// request stage, ram and response stage
// in a line, three-cycle read latency
// ========================================

`timescale 1ns/1ps

`include "spm_defines.svh"

module spm_top (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               cmd_v_i,   // command strobe, always accepted
  input  spm_pkg::spm_cmd_u  cmd_i,     // read or write command word
  output logic               resp_v_o,  // read response strobe, no back-pressure
  output spm_pkg::spm_resp_s resp_o     // tag plus data
);

  spm_pkg::spm_mem_req_s  mem_req;   // registered request
  logic [`SPM_DATA_W-1:0] rd_data;   // ram output register
  logic                   rd_v;      // read issued to the ram

  assign rd_v = mem_req.v & ~mem_req.w;

  // stage 1 decode and register
  spm_req_stage req0 (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .cmd_v_i   (cmd_v_i),
    .cmd_i     (cmd_i),
    .mem_req_o (mem_req)
  );

  // stage 2 ram access
  spm_mem_1rw_sync #(
    .data_w_p (`SPM_DATA_W),
    .depth_p  (`SPM_DEPTH)
  ) mem0 (
    .clk_i  (clk_i),
    .v_i    (mem_req.v),
    .w_i    (mem_req.w),
    .addr_i (mem_req.addr),
    .data_i (mem_req.data),
    .data_o (rd_data)
  );

  // stage 3 tag alignment and response register
  spm_resp_stage resp0 (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .rd_v_i    (rd_v),
    .tag_i     (mem_req.tag),
    .rd_data_i (rd_data),
    .resp_v_o  (resp_v_o),
    .resp_o    (resp_o)
  );

endmodule

// File: sim/spm_props.sv
// ========================================
// spm checker
// reference memory and expected response
// pipe bound into spm_top
// ========================================

`timescale 1ns/1ps

`include "spm_defines.svh"

module spm_props (
  input logic               clk_i,
  input logic               rst_i,
  input logic               cmd_v_i,
  input spm_pkg::spm_cmd_u  cmd_i,
  input logic               resp_v_o,
  input spm_pkg::spm_resp_s resp_o
);

  // one slot of the expected response pipe
  typedef struct packed {
    logic                   v;         // a read sits in this slot
    logic [`SPM_TAG_W-1:0]  tag;       // tag the client sent
    logic [`SPM_DATA_W-1:0] data;      // shadow contents at issue time
    logic                   raw;       // read right behind a write to the same word
    logic [`SPM_DATA_W-1:0] raw_data;  // data of that write
  } exp_s;

  logic [`SPM_DATA_W-1:0] shadow [`SPM_DEPTH];  // last value written per word
  exp_s [2:0]             exp_q;                // slot 2 is due at the port
  logic                   wr_cmd;
  logic                   rd_cmd;
  logic                   seen_rd;              // a read has been issued since reset
  logic                   last_wr_v;            // previous cycle carried a write
  logic [`SPM_ADDR_W-1:0] last_wr_addr;
  logic [`SPM_DATA_W-1:0] last_wr_data;
  int                     fail_cnt = 0;         // number of failed checks

  assign wr_cmd = cmd_v_i & (cmd_i.wr.op == spm_pkg::SPM_OP_WRITE);
  assign rd_cmd = cmd_v_i & (cmd_i.rd.op == spm_pkg::SPM_OP_READ);

  // reference memory written in command order
  always_ff @(posedge clk_i)
  begin
    if (wr_cmd)
    begin
      shadow[cmd_i.wr.addr] <= cmd_i.wr.data;
    end
  end

  // expected responses shift one slot per cycle of read latency
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      exp_q     <= '0;
      seen_rd   <= 1'b0;
      last_wr_v <= 1'b0;
    end
    else
    begin
      exp_q[0].v        <= rd_cmd;
      exp_q[0].tag      <= cmd_i.rd.tag;
      exp_q[0].data     <= shadow[cmd_i.rd.addr];  // sees writes up to last cycle
      exp_q[0].raw      <= rd_cmd & last_wr_v & (cmd_i.rd.addr == last_wr_addr);
      exp_q[0].raw_data <= last_wr_data;
      exp_q[2:1]        <= exp_q[1:0];
      seen_rd           <= seen_rd | rd_cmd;
      last_wr_v         <= wr_cmd;
      last_wr_addr      <= cmd_i.wr.addr;
      last_wr_data      <= cmd_i.wr.data;
    end
  end

  // quiet port until the first read
  a_idle_after_reset : assert property (
    @(posedge clk_i) disable iff (rst_i)
    !seen_rd |-> !resp_v_o)
  else
  begin
    fail_cnt++;
    $error("FAIL idle_after_reset expected resp_v_o=0 actual %b", $sampled(resp_v_o));
  end

  // three cycles from command to response
  a_read_latency : assert property (
    @(posedge clk_i) disable iff (rst_i)
    rd_cmd |-> ##3 resp_v_o)
  else
  begin
    fail_cnt++;
    $error("FAIL read_latency expected resp_v_o=1 actual %b", $sampled(resp_v_o));
  end

  // writes and idle cycles never make a response
  a_no_extra_resp : assert property (
    @(posedge clk_i) disable iff (rst_i)
    !rd_cmd |-> ##3 !resp_v_o)
  else
  begin
    fail_cnt++;
    $error("FAIL no_extra_resp expected resp_v_o=0 actual %b", $sampled(resp_v_o));
  end

  a_read_tag : assert property (
    @(posedge clk_i) disable iff (rst_i)
    (resp_v_o && exp_q[2].v) |-> (resp_o.tag == exp_q[2].tag))
  else
  begin
    fail_cnt++;
    $error("FAIL read_tag expected %h actual %h",
           $sampled(exp_q[2].tag), $sampled(resp_o.tag));
  end

  a_read_data : assert property (
    @(posedge clk_i) disable iff (rst_i)
    (resp_v_o && exp_q[2].v) |-> (resp_o.data == exp_q[2].data))
  else
  begin
    fail_cnt++;
    $error("FAIL read_data expected %h actual %h",
           $sampled(exp_q[2].data), $sampled(resp_o.data));
  end

  // read of a word written on the cycle before
  a_read_after_write : assert property (
    @(posedge clk_i) disable iff (rst_i)
    (resp_v_o && exp_q[2].v && exp_q[2].raw) |-> (resp_o.data == exp_q[2].raw_data))
  else
  begin
    fail_cnt++;
    $error("FAIL read_after_write expected %h actual %h",
           $sampled(exp_q[2].raw_data), $sampled(resp_o.data));
  end

endmodule

bind spm_top spm_props props0 (
  .clk_i    (clk_i),
  .rst_i    (rst_i),
  .cmd_v_i  (cmd_v_i),
  .cmd_i    (cmd_i),
  .resp_v_o (resp_v_o),
  .resp_o   (resp_o)
);

// File: sim/spm_tb.sv
// ========================================
// spm testbench
// fill, random mix, write-read pairs and
// a read burst, checked by spm_props
// ========================================

`timescale 1ns/1ps

`include "spm_defines.svh"

module spm_tb;

  localparam int          clk_period_lp   = 100;          // ns
  localparam int          reset_cycles_lp = 16;
  localparam int          fill_n_lp       = `SPM_DEPTH;   // every word once
  localparam int          mixed_n_lp      = 400;
  localparam int          pair_n_lp       = 48;           // two commands each
  localparam int          burst_n_lp      = 96;
  localparam int          drain_n_lp      = 8;            // last reads come back
  localparam int          total_cycles_lp = reset_cycles_lp + fill_n_lp + mixed_n_lp
                                            + 2 * pair_n_lp + burst_n_lp + drain_n_lp;
  localparam int          watchdog_ns_lp  = total_cycles_lp * clk_period_lp * 3 / 2;
  localparam logic [31:0] seed_lp         = 32'h1d63;

  logic               clk_i;
  logic               rst_i;
  logic               cmd_v_i;
  spm_pkg::spm_cmd_u  cmd_i;
  logic               resp_v_o;
  spm_pkg::spm_resp_s resp_o;

  spm_top dut0 (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .cmd_v_i  (cmd_v_i),
    .cmd_i    (cmd_i),
    .resp_v_o (resp_v_o),
    .resp_o   (resp_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #(clk_period_lp / 2) clk_i = ~clk_i;
  end

  // hang guard, half again the planned run length
  initial
  begin
    #(watchdog_ns_lp);
    $display("Test failed");
    $fatal(1, "watchdog expired before the stimulus finished");
  end

  // stop at the first failed assertion
  always @(negedge clk_i)
  begin
    if (dut0.props0.fail_cnt != 0)
    begin
      $display("Test failed");
      $fatal(1, "an assertion in spm_props failed");
    end
  end

  // one write command on the next rising edge
  task automatic send_write(input logic [`SPM_ADDR_W-1:0] addr,
                            input logic [`SPM_DATA_W-1:0] data);
    spm_pkg::spm_cmd_u cmd;
    cmd         = '0;
    cmd.wr.op   = spm_pkg::SPM_OP_WRITE;
    cmd.wr.addr = addr;
    cmd.wr.data = data;
    @(posedge clk_i);
    cmd_v_i <= 1'b1;
    cmd_i   <= cmd;
  endtask

  // one read command, reserved bits filled with noise
  task automatic send_read(input logic [`SPM_ADDR_W-1:0] addr,
                           input logic [`SPM_TAG_W-1:0]  tag);
    spm_pkg::spm_cmd_u cmd;
    logic [31:0]       noise;
    noise       = $urandom;
    cmd.rd.op   = spm_pkg::SPM_OP_READ;
    cmd.rd.addr = addr;
    cmd.rd.tag  = tag;
    cmd.rd.rsvd = noise[`SPM_DATA_W-`SPM_TAG_W-1:0];  // must be ignored
    @(posedge clk_i);
    cmd_v_i <= 1'b1;
    cmd_i   <= cmd;
  endtask

  task automatic go_idle(input int cycles);
    repeat (cycles)
    begin
      @(posedge clk_i);
      cmd_v_i <= 1'b0;
    end
  endtask

  initial
  begin
    logic [31:0]            rnd;
    logic [`SPM_ADDR_W-1:0] addr;
    logic [`SPM_ADDR_W-1:0] base;
    rnd     = $urandom(seed_lp);   // seeds the generator once
    rst_i   = 1'b1;
    cmd_v_i = 1'b0;
    cmd_i   = '0;
    repeat (reset_cycles_lp) @(posedge clk_i);
    rst_i <= 1'b0;

    // every word written, no reads yet
    for (int i = 0; i < fill_n_lp; i++)
    begin
      rnd = $urandom;
      send_write(i[`SPM_ADDR_W-1:0], rnd);
    end

    // random mix, all words hold known data by now
    for (int i = 0; i < mixed_n_lp; i++)
    begin
      rnd  = $urandom;
      addr = rnd[`SPM_ADDR_W-1:0];
      if (rnd[8])
      begin
        send_write(addr, $urandom);
      end
      else
      begin
        send_read(addr, rnd[23:16]);
      end
    end

    // read on the cycle right after the write
    for (int i = 0; i < pair_n_lp; i++)
    begin
      rnd  = $urandom;
      addr = rnd[`SPM_ADDR_W-1:0];
      send_write(addr, $urandom);
      send_read(addr, rnd[15:8]);
    end

    // reads on every cycle, three in flight
    rnd  = $urandom;
    base = rnd[`SPM_ADDR_W-1:0];
    for (int i = 0; i < burst_n_lp; i++)
    begin
      send_read(base + i[`SPM_ADDR_W-1:0], i[`SPM_TAG_W-1:0]);
    end

    go_idle(drain_n_lp);

    if (dut0.props0.fail_cnt == 0)
    begin
      $display("Test completed successfully");
      $finish;
    end
    else
    begin
      $display("Test failed");
      $fatal(1, "%0d assertion failures", dut0.props0.fail_cnt);
    end
  end

endmodule

// File: compile.f
+incdir+design
design/spm_pkg.sv
design/spm_req_stage.sv
design/spm_mem_1rw_sync.sv
design/spm_resp_stage.sv
design/spm_top.sv
sim/spm_props.sv
sim/spm_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := spm_tb
FILELIST   := compile.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Test completed successfully
VFLAGS     := --timing --assert -top-module $(TOP) -f $(FILELIST)
LINT_FLAGS := --lint-only $(VFLAGS)
BUILD_FLAGS := --binary $(VFLAGS) -Mdir $(BUILD_DIR)
SIM_ARGS   := +verilator+error+limit+100

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS)

build:
	$(VERILATOR) $(BUILD_FLAGS)

sim: build
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
